/* src/CacheTypes.sv */
package CacheTypes;

    // Byte address width of the core.
    localparam int ADDR_WIDTH = 32;

    localparam int DCACHE_LINE_SIZE = 16;                   // Bytes per line.
    localparam int DCACHE_LINE_WIDTH = DCACHE_LINE_SIZE * 8;
    localparam int DCACHE_SETS = 64;                        // Direct mapped.

    localparam int DCACHE_OFFSET_WIDTH = $clog2(DCACHE_LINE_SIZE);
    localparam int DCACHE_INDEX_WIDTH = $clog2(DCACHE_SETS);
    localparam int DCACHE_TAG_WIDTH =
        ADDR_WIDTH - DCACHE_INDEX_WIDTH - DCACHE_OFFSET_WIDTH;
    localparam int DCACHE_LINE_ADDR_WIDTH = DCACHE_TAG_WIDTH + DCACHE_INDEX_WIDTH;

    localparam int STORE_BUFFER_DEPTH = 4;                  // Pending stores.
    localparam int STORE_BUFFER_INDEX_WIDTH = $clog2(STORE_BUFFER_DEPTH);

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DCACHE_OFFSET_WIDTH-1:0] offset_t;
    typedef logic [DCACHE_INDEX_WIDTH-1:0] index_t;
    typedef logic [DCACHE_TAG_WIDTH-1:0] tag_t;

    // Tag in the upper bits, index in the lower bits.
    typedef logic [DCACHE_LINE_ADDR_WIDTH-1:0] lineAddr_t;

    // Byte 0 of the line sits in bits 7:0.
    typedef logic [DCACHE_LINE_WIDTH-1:0] lineData_t;
    typedef logic [DCACHE_LINE_SIZE-1:0] byteMask_t;

    typedef logic [STORE_BUFFER_INDEX_WIDTH-1:0] sbIndex_t;
    typedef logic [STORE_BUFFER_INDEX_WIDTH:0] sbCount_t;  // One extra bit for full.

endpackage

/* src/OpTypes.sv */
package OpTypes;

    localparam int DATA_WIDTH = 64;
    localparam int DATA_BYTES = DATA_WIDTH / 8;    // Bytes in a data word.

    typedef logic [DATA_WIDTH-1:0] uint64_t;

    // Load and store access types.
    // Stores only use the four signed encodings.
    typedef enum logic [2:0] {
        LoadStoreType_Byte             = 3'd0,
        LoadStoreType_HalfWord         = 3'd1,
        LoadStoreType_Word             = 3'd2,
        LoadStoreType_DoubleWord       = 3'd3,
        LoadStoreType_UnsignedByte     = 3'd4,
        LoadStoreType_UnsignedHalfWord = 3'd5,
        LoadStoreType_UnsignedWord     = 3'd6,
        LoadStoreType_FpWord           = 3'd7   // NaN-boxed single float.
    } LoadStoreType;

endpackage

/* src/DcacheArray.sv */
`timescale 1ns/10ps

module DcacheArray (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  fillValid,
    input  CacheTypes::addr_t     fillAddr,
    input  CacheTypes::lineData_t fillLine,
    input  logic                  drainValid,
    input  CacheTypes::lineAddr_t drainLineAddr,
    input  CacheTypes::byteMask_t drainMask,
    input  CacheTypes::lineData_t drainData,
    input  logic                  loadValid,
    input  CacheTypes::addr_t     loadAddr,
    output CacheTypes::lineData_t readLine,
    output logic                  readHit
);
    import CacheTypes::*;

    lineData_t dataArray [DCACHE_SETS];
    tag_t tagArray [DCACHE_SETS];
    logic [DCACHE_SETS-1:0] validArray;

    index_t fillIndex;
    tag_t fillTag;
    index_t drainIndex;
    tag_t drainTag;
    index_t loadIndex;
    tag_t loadTag;
    logic drainTagMatch;
    logic drainWrite;

    assign fillIndex = fillAddr[DCACHE_OFFSET_WIDTH +: DCACHE_INDEX_WIDTH];
    assign fillTag = fillAddr[ADDR_WIDTH-1 -: DCACHE_TAG_WIDTH];
    assign drainIndex = drainLineAddr[DCACHE_INDEX_WIDTH-1:0];
    assign drainTag = drainLineAddr[DCACHE_LINE_ADDR_WIDTH-1 -: DCACHE_TAG_WIDTH];
    assign loadIndex = loadAddr[DCACHE_OFFSET_WIDTH +: DCACHE_INDEX_WIDTH];
    assign loadTag = loadAddr[ADDR_WIDTH-1 -: DCACHE_TAG_WIDTH];

    // A fill to the drained set in the same edge decides residency,
    // so the drained bytes land on top of the freshly filled line.
    always_comb begin
        drainTagMatch = validArray[drainIndex] && (tagArray[drainIndex] == drainTag);
        if (fillValid && (fillIndex == drainIndex)) begin
            drainTagMatch = (fillTag == drainTag);
        end
        drainWrite = drainValid && drainTagMatch;    // No write allocate.
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validArray <= '0;
        end else if (fillValid) begin
            validArray[fillIndex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fillValid) begin
            dataArray[fillIndex] <= fillLine;
            tagArray[fillIndex] <= fillTag;
        end
        if (drainWrite) begin
            for (int i = 0; i < DCACHE_LINE_SIZE; i++) begin
                if (drainMask[i]) begin
                    dataArray[drainIndex][i*8 +: 8] <= drainData[i*8 +: 8];
                end
            end
        end
    end

    // Reads see the array as it was before this edge.
    always_ff @(posedge clk) begin
        if (loadValid) begin
            readLine <= dataArray[loadIndex];
            readHit <= validArray[loadIndex] && (tagArray[loadIndex] == loadTag);
        end
    end

endmodule

/* src/StoreBuffer.sv */
`timescale 1ns/10ps

module StoreBuffer (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   storeValid,
    input  CacheTypes::addr_t      storeAddr,
    input  OpTypes::uint64_t       storeData,
    input  OpTypes::LoadStoreType  storeType,
    input  logic                   loadValid,
    input  CacheTypes::addr_t      loadAddr,
    output logic                   drainValid,
    output CacheTypes::lineAddr_t  drainLineAddr,
    output CacheTypes::byteMask_t  drainMask,
    output CacheTypes::lineData_t  drainData,
    output CacheTypes::lineData_t  fwdLine,
    output CacheTypes::byteMask_t  fwdMask,
    output logic                   storeFull
);
    import CacheTypes::*;
    import OpTypes::*;

    lineAddr_t entryLineAddr [STORE_BUFFER_DEPTH];
    byteMask_t entryMask [STORE_BUFFER_DEPTH];
    lineData_t entryData [STORE_BUFFER_DEPTH];

    sbIndex_t head;     // Oldest entry.
    sbIndex_t tail;     // Next free slot.
    sbCount_t count;

    offset_t storeOffset;
    byteMask_t storeMask;
    lineData_t storeLine;
    logic push;
    logic pop;

    lineAddr_t loadLineAddr;
    lineData_t mergedLine;
    byteMask_t mergedMask;

    function automatic byteMask_t SizeMask(LoadStoreType opType);
        case (opType)
            LoadStoreType_Byte:     return byteMask_t'(1'b1);
            LoadStoreType_HalfWord: return byteMask_t'(2'b11);
            LoadStoreType_Word:     return byteMask_t'(4'hf);
            default:                return byteMask_t'({DATA_BYTES{1'b1}});
        endcase
    endfunction

    // Place the store at its byte offset in the line.
    assign storeOffset = storeAddr[DCACHE_OFFSET_WIDTH-1:0];
    assign storeMask = SizeMask(storeType) << storeOffset;
    assign storeLine = lineData_t'(storeData) << {storeOffset, 3'b000};

    assign storeFull = (count == sbCount_t'(STORE_BUFFER_DEPTH));
    assign push = storeValid && !storeFull;

    // Drain only in cycles the array read port is free.
    assign drainValid = (count != '0) && !loadValid;
    assign pop = drainValid;
    assign drainLineAddr = entryLineAddr[head];
    assign drainMask = entryMask[head];
    assign drainData = entryData[head];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + sbCount_t'(push) - sbCount_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entryLineAddr[tail] <= storeAddr[ADDR_WIDTH-1:DCACHE_OFFSET_WIDTH];
            entryMask[tail] <= storeMask;
            entryData[tail] <= storeLine;
        end
    end

    assign loadLineAddr = loadAddr[ADDR_WIDTH-1:DCACHE_OFFSET_WIDTH];

    // Walk oldest to youngest so younger bytes overwrite older ones.
    always_comb begin
        sbIndex_t idx;
        mergedLine = '0;
        mergedMask = '0;
        for (int k = 0; k < STORE_BUFFER_DEPTH; k++) begin
            idx = head + sbIndex_t'(k);
            if ((sbCount_t'(k) < count) && (entryLineAddr[idx] == loadLineAddr)) begin
                for (int b = 0; b < DCACHE_LINE_SIZE; b++) begin
                    if (entryMask[idx][b]) begin
                        mergedLine[b*8 +: 8] = entryData[idx][b*8 +: 8];
                        mergedMask[b] = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loadValid) begin
            fwdLine <= mergedLine;
            fwdMask <= mergedMask;
        end
    end

endmodule

/* src/LoadValueUnit.sv */
`timescale 1ns/10ps

module LoadValueUnit (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  loadValid,
    input  CacheTypes::addr_t     loadAddr,
    input  OpTypes::LoadStoreType loadType,
    input  CacheTypes::lineData_t readLine,
    input  logic                  readHit,
    input  CacheTypes::lineData_t fwdLine,
    input  CacheTypes::byteMask_t fwdMask,
    output logic                  resultValid,
    output OpTypes::uint64_t      result,
    output logic                  resultHit
);
    import CacheTypes::*;
    import OpTypes::*;

    logic validReg;
    offset_t offsetReg;
    LoadStoreType typeReg;

    lineData_t mergedLine;
    uint64_t shiftedValue;

    // Pending store bytes take priority over the array.
    function automatic lineData_t MergeForward(lineData_t line, lineData_t fwd,
                                               byteMask_t mask);
        lineData_t merged;
        merged = line;
        for (int b = 0; b < DCACHE_LINE_SIZE; b++) begin
            if (mask[b]) begin
                merged[b*8 +: 8] = fwd[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    function automatic uint64_t ShiftDown(lineData_t line, offset_t offset);
        uint64_t value;
        int pos;
        value = '0;     // Bytes past the line end stay zero.
        for (int i = 0; i < DATA_BYTES; i++) begin
            pos = int'(offset) + i;
            if (pos < DCACHE_LINE_SIZE) begin
                value[i*8 +: 8] = line[pos*8 +: 8];
            end
        end
        return value;
    endfunction

    function automatic uint64_t Extend(uint64_t value, LoadStoreType opType);
        case (opType)
            LoadStoreType_Byte:             return {{56{value[7]}}, value[7:0]};
            LoadStoreType_HalfWord:         return {{48{value[15]}}, value[15:0]};
            LoadStoreType_Word:             return {{32{value[31]}}, value[31:0]};
            LoadStoreType_DoubleWord:       return value;
            LoadStoreType_UnsignedByte:     return {56'h0, value[7:0]};
            LoadStoreType_UnsignedHalfWord: return {48'h0, value[15:0]};
            LoadStoreType_UnsignedWord:     return {32'h0, value[31:0]};
            LoadStoreType_FpWord:           return {32'hffff_ffff, value[31:0]};
            default:                        return '0;
        endcase
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validReg <= 1'b0;
        end else begin
            validReg <= loadValid;
        end
    end

    // Aligned with the array and forward registers.
    always_ff @(posedge clk) begin
        if (loadValid) begin
            offsetReg <= loadAddr[DCACHE_OFFSET_WIDTH-1:0];
            typeReg <= loadType;
        end
    end

    assign mergedLine = MergeForward(readLine, fwdLine, fwdMask);
    assign shiftedValue = ShiftDown(mergedLine, offsetReg);

    assign resultValid = validReg;
    assign result = Extend(shiftedValue, typeReg);
    assign resultHit = readHit;     // Forwarding does not make a hit.

endmodule

/* src/DcacheLoadPath.sv */
`timescale 1ns/10ps

module DcacheLoadPath (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  fillValid,
    input  CacheTypes::addr_t     fillAddr,
    input  CacheTypes::lineData_t fillLine,
    input  logic                  storeValid,
    input  CacheTypes::addr_t     storeAddr,
    input  OpTypes::uint64_t      storeData,
    input  OpTypes::LoadStoreType storeType,
    output logic                  storeFull,
    input  logic                  loadValid,
    input  CacheTypes::addr_t     loadAddr,
    input  OpTypes::LoadStoreType loadType,
    output logic                  resultValid,
    output OpTypes::uint64_t      result,
    output logic                  resultHit
);
    import CacheTypes::*;

    logic drainValid;
    lineAddr_t drainLineAddr;
    byteMask_t drainMask;
    lineData_t drainData;

    lineData_t readLine;    // Array read, one cycle after the load.
    logic readHit;
    lineData_t fwdLine;     // Store buffer bytes for the same line.
    byteMask_t fwdMask;

    DcacheArray u_DcacheArray (
        .clk           (clk),
        .arstN         (arstN),
        .fillValid     (fillValid),
        .fillAddr      (fillAddr),
        .fillLine      (fillLine),
        .drainValid    (drainValid),
        .drainLineAddr (drainLineAddr),
        .drainMask     (drainMask),
        .drainData     (drainData),
        .loadValid     (loadValid),
        .loadAddr      (loadAddr),
        .readLine      (readLine),
        .readHit       (readHit)
    );

    StoreBuffer u_StoreBuffer (
        .clk           (clk),
        .arstN         (arstN),
        .storeValid    (storeValid),
        .storeAddr     (storeAddr),
        .storeData     (storeData),
        .storeType     (storeType),
        .loadValid     (loadValid),
        .loadAddr      (loadAddr),
        .drainValid    (drainValid),
        .drainLineAddr (drainLineAddr),
        .drainMask     (drainMask),
        .drainData     (drainData),
        .fwdLine       (fwdLine),
        .fwdMask       (fwdMask),
        .storeFull     (storeFull)
    );

    LoadValueUnit u_LoadValueUnit (
        .clk         (clk),
        .arstN       (arstN),
        .loadValid   (loadValid),
        .loadAddr    (loadAddr),
        .loadType    (loadType),
        .readLine    (readLine),
        .readHit     (readHit),
        .fwdLine     (fwdLine),
        .fwdMask     (fwdMask),
        .resultValid (resultValid),
        .result      (result),
        .resultHit   (resultHit)
    );

endmodule

/* tb/DcacheLoadPathTb.sv */
`timescale 1ns/10ps

module DcacheLoadPathTb;
    import CacheTypes::*;
    import OpTypes::*;

    localparam int CYCLE_LIMIT = 3000;      // About four times the test length.
    localparam tag_t TAG_A = 22'h0_1234;
    localparam tag_t TAG_B = 22'h2_abcd;

    logic clk;
    logic arstN;
    logic fillValid;
    addr_t fillAddr;
    lineData_t fillLine;
    logic storeValid;
    addr_t storeAddr;
    uint64_t storeData;
    LoadStoreType storeType;
    logic storeFull;
    logic loadValid;
    addr_t loadAddr;
    LoadStoreType loadType;
    logic resultValid;
    uint64_t result;
    logic resultHit;

    // Byte model of the array contents and the pending stores.
    lineData_t memLine [DCACHE_SETS];
    tag_t memTag [DCACHE_SETS];
    logic memValid [DCACHE_SETS];
    lineAddr_t pendLine [$];                // Index 0 is the oldest store.
    byteMask_t pendMask [$];
    lineData_t pendData [$];

    uint64_t expResult [$];
    logic expHit [$];
    logic expDataKnown [$];                 // Set never filled means array data is unknown.

    string testName;
    int checks;
    int errors;
    int cycleCount;
    logic [31:0] lfsrState;

    DcacheLoadPath u_DcacheLoadPath (
        .clk         (clk),
        .arstN       (arstN),
        .fillValid   (fillValid),
        .fillAddr    (fillAddr),
        .fillLine    (fillLine),
        .storeValid  (storeValid),
        .storeAddr   (storeAddr),
        .storeData   (storeData),
        .storeType   (storeType),
        .storeFull   (storeFull),
        .loadValid   (loadValid),
        .loadAddr    (loadAddr),
        .loadType    (loadType),
        .resultValid (resultValid),
        .result      (result),
        .resultHit   (resultHit)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    // One step for each bit taken.
    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v[i] = lfsrState[0];
        end
        return v;
    endfunction

    function automatic lineData_t randomLine();
        lineData_t line;
        for (int i = 0; i < 4; i++) begin
            line[i*32 +: 32] = randBits(32);
        end
        return line;
    endfunction

    function automatic addr_t makeAddr(tag_t tag, index_t index, offset_t offset);
        return {tag, index, offset};
    endfunction

    function automatic int accessBytes(LoadStoreType t);
        case (t)
            LoadStoreType_Byte, LoadStoreType_UnsignedByte:         return 1;
            LoadStoreType_HalfWord, LoadStoreType_UnsignedHalfWord: return 2;
            LoadStoreType_DoubleWord:                               return 8;
            default:                                                return 4;
        endcase
    endfunction

    // Youngest pending store wins over the resident byte.
    function automatic logic [7:0] modelByte(lineAddr_t line, int pos);
        logic [7:0] b;
        b = memLine[line[DCACHE_INDEX_WIDTH-1:0]][pos*8 +: 8];
        foreach (pendLine[k]) begin
            if ((pendLine[k] == line) && pendMask[k][pos]) begin
                b = pendData[k][pos*8 +: 8];
            end
        end
        return b;
    endfunction

    function automatic uint64_t modelLoad(addr_t addr, LoadStoreType t);
        uint64_t value;
        int size;
        int pos;
        logic [7:0] pad;
        value = '0;
        size = accessBytes(t);
        for (int i = 0; i < size; i++) begin
            pos = int'(addr[DCACHE_OFFSET_WIDTH-1:0]) + i;
            if (pos < DCACHE_LINE_SIZE) begin
                value[i*8 +: 8] = modelByte(addr[ADDR_WIDTH-1:DCACHE_OFFSET_WIDTH], pos);
            end
        end
        pad = 8'h00;
        if (t inside {LoadStoreType_Byte, LoadStoreType_HalfWord, LoadStoreType_Word}) begin
            pad = {8{value[size*8-1]}};
        end else if (t == LoadStoreType_FpWord) begin
            pad = 8'hff;                    // NaN box.
        end
        for (int i = size; i < DATA_BYTES; i++) begin
            value[i*8 +: 8] = pad;
        end
        return value;
    endfunction

    task automatic checkValue(string what, logic [63:0] expected, logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    // Mirrors one clock edge. Loads see the state from before the edge.
    task automatic modelEdge();
        index_t idx;
        tag_t drainTag;
        int size;
        int off;
        if (loadValid) begin
            idx = loadAddr[DCACHE_OFFSET_WIDTH +: DCACHE_INDEX_WIDTH];
            expResult.push_back(modelLoad(loadAddr, loadType));
            expHit.push_back(memValid[idx] &&
                             (memTag[idx] == loadAddr[ADDR_WIDTH-1 -: DCACHE_TAG_WIDTH]));
            expDataKnown.push_back(memValid[idx]);
        end
        if (fillValid) begin
            idx = fillAddr[DCACHE_OFFSET_WIDTH +: DCACHE_INDEX_WIDTH];
            memLine[idx] = fillLine;
            memTag[idx] = fillAddr[ADDR_WIDTH-1 -: DCACHE_TAG_WIDTH];
            memValid[idx] = 1'b1;
        end
        if (!loadValid && (pendLine.size() > 0)) begin
            idx = pendLine[0][DCACHE_INDEX_WIDTH-1:0];
            drainTag = pendLine[0][DCACHE_LINE_ADDR_WIDTH-1 -: DCACHE_TAG_WIDTH];
            if (memValid[idx] && (memTag[idx] == drainTag)) begin
                for (int b = 0; b < DCACHE_LINE_SIZE; b++) begin
                    if (pendMask[0][b]) begin
                        memLine[idx][b*8 +: 8] = pendData[0][b*8 +: 8];
                    end
                end
            end
            void'(pendLine.pop_front());
            void'(pendMask.pop_front());
            void'(pendData.pop_front());
        end
        if (storeValid) begin
            off = int'(storeAddr[DCACHE_OFFSET_WIDTH-1:0]);
            size = accessBytes(storeType);
            pendLine.push_back(storeAddr[ADDR_WIDTH-1:DCACHE_OFFSET_WIDTH]);
            pendMask.push_back(byteMask_t'(((1 << size) - 1) << off));
            pendData.push_back(lineData_t'(storeData) << (off * 8));
        end
    endtask

    // One cycle with the caller's strobes. Results are checked at the falling edge.
    task automatic tick();
        logic wasLoad;
        wasLoad = loadValid;
        modelEdge();
        @(posedge clk);
        @(negedge clk);
        fillValid = 1'b0;
        storeValid = 1'b0;
        loadValid = 1'b0;
        checkValue("resultValid", wasLoad, resultValid);
        checkValue("storeFull", pendLine.size() == STORE_BUFFER_DEPTH, storeFull);
        if (wasLoad) begin
            checkValue("resultHit", expHit[0], resultHit);
            if (expDataKnown[0]) begin
                checkValue("result", expResult[0], result);
            end
            void'(expResult.pop_front());
            void'(expHit.pop_front());
            void'(expDataKnown.pop_front());
        end
    endtask

    task automatic setLoad(addr_t addr, LoadStoreType t);
        loadValid = 1'b1;
        loadAddr = addr;
        loadType = t;
    endtask

    task automatic setStore(addr_t addr, uint64_t data, LoadStoreType t);
        storeValid = 1'b1;
        storeAddr = addr;
        storeData = data;
        storeType = t;
    endtask

    task automatic setFill(addr_t addr, lineData_t line);
        fillValid = 1'b1;
        fillAddr = addr;
        fillLine = line;
    endtask

    task automatic loadOnce(addr_t addr, LoadStoreType t);
        setLoad(addr, t);
        tick();
    endtask

    task automatic fillAndTypedLoads();
        int offsets [4];
        testName = "fillAndTypedLoads";
        offsets = '{0, 3, 8, 13};
        for (int s = 1; s <= 3; s++) begin
            setFill(makeAddr(TAG_A, index_t'(s), 4'd0), randomLine());
            tick();
        end
        for (int t = 0; t < 8; t++) begin
            for (int k = 0; k < 4; k++) begin
                loadOnce(makeAddr(TAG_A, index_t'(1 + k % 3), offset_t'(offsets[k])),
                         LoadStoreType'(t));
            end
        end
    endtask

    task automatic missLoads();
        testName = "missLoads";
        loadOnce(makeAddr(TAG_A, 6'd40, 4'd0), LoadStoreType_DoubleWord);  // Never filled.
        loadOnce(makeAddr(TAG_B, 6'd1, 4'd8), LoadStoreType_Word);         // Other tag.
        loadOnce(makeAddr(TAG_B, 6'd3, 4'd0), LoadStoreType_UnsignedByte);
    endtask

    // Loads in every cycle hold back the drain.
    task automatic forwardAndFull();
        addr_t base;
        addr_t other;
        testName = "forwardAndFull";
        base = makeAddr(TAG_A, 6'd2, 4'd0);
        other = makeAddr(TAG_B, 6'd2, 4'd0);     // Same set under a tag that is not resident.
        setLoad(base, LoadStoreType_DoubleWord);
        setStore(base + 4, 64'h0000_0000_a1b2_c3d4, LoadStoreType_Word);
        tick();
        setLoad(base + 4, LoadStoreType_Word);
        setStore(base, 64'h1122_3344_5566_7788, LoadStoreType_DoubleWord);
        tick();
        setLoad(base, LoadStoreType_DoubleWord);
        setStore(base + 6, 64'h0000_0000_0000_eeff, LoadStoreType_HalfWord);
        tick();
        setLoad(base + 2, LoadStoreType_DoubleWord);
        setStore(other + 9, 64'h0000_0000_0000_005a, LoadStoreType_Byte);
        tick();
        checkValue("storeFull after four stores", 1'b1, storeFull);
        loadOnce(base, LoadStoreType_DoubleWord);
        loadOnce(base + 4, LoadStoreType_Word);
        loadOnce(base + 6, LoadStoreType_UnsignedHalfWord);
        loadOnce(base + 8, LoadStoreType_DoubleWord);
    endtask

    task automatic drainNoAllocate();
        addr_t base;
        addr_t other;
        testName = "drainNoAllocate";
        base = makeAddr(TAG_A, 6'd2, 4'd0);
        other = makeAddr(TAG_B, 6'd2, 4'd0);
        loadOnce(other + 8, LoadStoreType_DoubleWord);     // Pending byte forwarded on a miss.
        loadOnce(other + 9, LoadStoreType_UnsignedByte);
        for (int i = 0; i < 6; i++) begin
            tick();
        end
        checkValue("storeFull after drain", 1'b0, storeFull);
        loadOnce(base, LoadStoreType_DoubleWord);
        loadOnce(base + 8, LoadStoreType_DoubleWord);
        loadOnce(base + 4, LoadStoreType_Word);
        loadOnce(other + 8, LoadStoreType_DoubleWord);     // Dropped store.
        setStore(other + 12, 64'h0000_0000_9abc_def0, LoadStoreType_Word);
        tick();
        setFill(other, randomLine());                      // Store drains in the same edge.
        tick();
        loadOnce(other + 8, LoadStoreType_DoubleWord);
        loadOnce(other + 9, LoadStoreType_UnsignedByte);
    endtask

    task automatic lineEndAndBoxing();
        addr_t base;
        testName = "lineEndAndBoxing";
        base = makeAddr(TAG_A, 6'd7, 4'd0);
        setFill(base, 128'hf0e1_d2c3_b4a5_9687_7869_5a4b_3c2d_1e0f);
        tick();
        for (int off = 12; off < 16; off++) begin
            loadOnce(base + off, LoadStoreType_DoubleWord);
            loadOnce(base + off, LoadStoreType_Word);
            loadOnce(base + off, LoadStoreType_FpWord);
        end
        loadOnce(base, LoadStoreType_FpWord);
        loadOnce(base + 4, LoadStoreType_FpWord);
    endtask

    task automatic randomTraffic();
        logic [1:0] op;
        tag_t tag;
        index_t idx;
        offset_t off;
        LoadStoreType t;
        uint64_t data;
        testName = "randomTraffic";
        for (int s = 8; s < 12; s++) begin
            setFill(makeAddr(TAG_B, index_t'(s), 4'd0), randomLine());
            tick();
        end
        for (int n = 0; n < 650; n++) begin
            op = randBits(2);
            if (op[0]) begin
                tag = randBits(1) ? TAG_A : TAG_B;
                idx = index_t'(8 + randBits(2));
                setLoad(makeAddr(tag, idx, offset_t'(randBits(4))), LoadStoreType'(randBits(3)));
            end
            if (op[1] && (pendLine.size() < STORE_BUFFER_DEPTH)) begin
                t = LoadStoreType'(randBits(2));
                off = offset_t'(randBits(4) & ~(accessBytes(t) - 1));   // Natural alignment.
                data[63:32] = randBits(32);
                data[31:0] = randBits(32);
                tag = (randBits(3) == 0) ? TAG_A : TAG_B;
                idx = index_t'(8 + randBits(2));
                setStore(makeAddr(tag, idx, off), data, t);
            end
            tick();
        end
        while (pendLine.size() > 0) begin
            tick();
        end
    endtask

    initial begin
        clk = 1'b0;
        arstN = 1'b0;
        fillValid = 1'b0;
        fillAddr = '0;
        fillLine = '0;
        storeValid = 1'b0;
        storeAddr = '0;
        storeData = '0;
        storeType = LoadStoreType_Byte;
        loadValid = 1'b0;
        loadAddr = '0;
        loadType = LoadStoreType_Byte;
        checks = 0;
        errors = 0;
        cycleCount = 0;
        lfsrState = 32'h5235_45b9;
        testName = "reset";
        for (int i = 0; i < DCACHE_SETS; i++) begin
            memValid[i] = 1'b0;
        end
        repeat (4) @(negedge clk);
        arstN = 1'b1;
        checkValue("resultValid", 1'b0, resultValid);
        checkValue("storeFull", 1'b0, storeFull);
        fillAndTypedLoads();
        missLoads();
        forwardAndFull();
        drainNoAllocate();
        lineEndAndBoxing();
        randomTraffic();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* DcacheLoadPath.f */
src/CacheTypes.sv
src/OpTypes.sv
src/DcacheArray.sv
src/StoreBuffer.sv
src/LoadValueUnit.sv
src/DcacheLoadPath.sv
tb/DcacheLoadPathTb.sv
